//--- src/ht_pkg.sv
/*
 * Huffman coder shared definitions
 * sizes, node and code types, tie convention and output words
 */
package ht_pkg;

    // ==================
    // sizes
    // ==================
    localparam int NUM_SYM      = 8;
    localparam int NUM_NODE     = 2 * NUM_SYM - 1;   // root is the last node
    localparam int NUM_MERGE    = NUM_SYM - 1;
    localparam int WORD_LEN     = 5;
    localparam int MAX_CODE_LEN = 7;

    typedef logic [2:0] weight_t;
    typedef logic [5:0] node_wt_t;      // up to 8 * 7
    typedef logic [3:0] node_idx_t;
    typedef logic [2:0] sym_idx_t;

    localparam node_idx_t ROOT_NODE = node_idx_t'(NUM_NODE - 1);

    // lowest-ranked child of a merge takes branch bit 1
    localparam logic BRANCH_LOW  = 1'b1;
    localparam logic BRANCH_HIGH = 1'b0;

    // symbol indices in input order
    localparam sym_idx_t SYM_A = 3'd0;
    localparam sym_idx_t SYM_B = 3'd1;
    localparam sym_idx_t SYM_C = 3'd2;
    localparam sym_idx_t SYM_E = 3'd3;
    localparam sym_idx_t SYM_I = 3'd4;
    localparam sym_idx_t SYM_L = 3'd5;
    localparam sym_idx_t SYM_O = 3'd6;
    localparam sym_idx_t SYM_V = 3'd7;

    typedef struct packed {
        logic                     mode;
        weight_t [NUM_SYM-1:0]    weight;
    } weight_frame_t;

    typedef struct packed {
        node_idx_t [NUM_NODE-2:0] parent;
        logic [NUM_NODE-2:0]      branch;
    } huff_tree_t;

    typedef struct packed {
        logic [2:0]               len;
        logic [MAX_CODE_LEN-1:0]  bits;    // right-aligned
    } code_entry_t;

    typedef struct packed {
        code_entry_t [NUM_SYM-1:0] entry;
    } code_table_t;

    // first letter sits in element 0
    localparam sym_idx_t [WORD_LEN-1:0] WORD_ILOVE = {SYM_E, SYM_V, SYM_O, SYM_L, SYM_I};
    localparam sym_idx_t [WORD_LEN-1:0] WORD_ICLAB = {SYM_B, SYM_A, SYM_L, SYM_C, SYM_I};

endpackage

//--- src/ht_weight_collect.sv
/*
 * Weight collector
 * captures eight serial weights and the mode into one frame
 */
`timescale 1ns/1ps

module ht_weight_collect import ht_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_in_valid,
    input  weight_t       i_weight,
    input  logic          i_out_mode,
    output logic          o_frame_valid,
    output weight_frame_t o_frame
);

    logic [2:0]    slot_q;
    logic          frame_valid_q;
    weight_frame_t frame_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q        <= '0;
            frame_valid_q <= 1'b0;
        end else begin
            frame_valid_q <= i_in_valid && (slot_q == 3'(NUM_SYM - 1));
            if (i_in_valid) begin
                slot_q <= slot_q + 3'd1;   // wraps after slot 7
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            frame_q.weight[slot_q] <= i_weight;
            if (slot_q == 3'd0) begin
                frame_q.mode <= i_out_mode;   // mode rides with the first weight
            end
        end
    end

    assign o_frame_valid = frame_valid_q;
    assign o_frame       = frame_q;

    // weights arrive as one unbroken burst of eight
    a_burst_whole: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_q != 3'd0) |-> i_in_valid);

endmodule

//--- src/ht_tree_build.sv
/*
 * Huffman tree builder
 * one load cycle, then one merge per cycle of the two lowest-ranked
 * live nodes until only the root is left
 */
`timescale 1ns/1ps

module ht_tree_build import ht_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_frame_valid,
    input  weight_frame_t i_frame,
    output logic          o_tree_valid,
    output huff_tree_t    o_tree,
    output logic          o_mode
);

    node_wt_t            wt_q [NUM_NODE];
    logic [NUM_NODE-1:0] live_q;
    logic                busy;
    logic [2:0]          step;
    logic                tree_valid_q;
    huff_tree_t          tree_q;
    logic                mode_q;

    node_idx_t           min1;   // lowest ranked
    node_idx_t           min2;
    node_idx_t           new_idx;

    assign new_idx = node_idx_t'(NUM_SYM) + {1'b0, step};

    // ==================
    // rank search
    // ==================
    // ascending scan with <= lets the higher index win a tie
    always_comb begin : rank_search
        logic     found1;
        logic     found2;
        node_wt_t best1;
        node_wt_t best2;
        found1 = 1'b0;
        found2 = 1'b0;
        best1  = '0;
        best2  = '0;
        min1   = '0;
        min2   = '0;
        for (int i = 0; i < NUM_NODE; i++) begin
            if (live_q[i] && (!found1 || wt_q[i] <= best1)) begin
                found1 = 1'b1;
                best1  = wt_q[i];
                min1   = node_idx_t'(i);
            end
        end
        for (int i = 0; i < NUM_NODE; i++) begin
            if (live_q[i] && node_idx_t'(i) != min1 && (!found2 || wt_q[i] <= best2)) begin
                found2 = 1'b1;
                best2  = wt_q[i];
                min2   = node_idx_t'(i);
            end
        end
    end

    // ==================
    // merge control
    // ==================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            step         <= '0;
            live_q       <= '0;
            tree_valid_q <= 1'b0;
        end else begin
            tree_valid_q <= 1'b0;
            if (i_frame_valid) begin
                busy                  <= 1'b1;
                step                  <= '0;
                live_q                <= '0;
                live_q[NUM_SYM-1:0]   <= '1;   // leaves only
            end else if (busy) begin
                live_q[min1]    <= 1'b0;
                live_q[min2]    <= 1'b0;
                live_q[new_idx] <= 1'b1;
                step            <= step + 3'd1;
                if (step == 3'(NUM_MERGE - 1)) begin
                    busy         <= 1'b0;
                    tree_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_frame_valid) begin
            for (int i = 0; i < NUM_SYM; i++) begin
                wt_q[i] <= {3'b000, i_frame.weight[i]};
            end
            mode_q <= i_frame.mode;
        end else if (busy) begin
            wt_q[new_idx]        <= wt_q[min1] + wt_q[min2];
            tree_q.parent[min1]  <= new_idx;
            tree_q.branch[min1]  <= BRANCH_LOW;
            tree_q.parent[min2]  <= new_idx;
            tree_q.branch[min2]  <= BRANCH_HIGH;
        end
    end

    assign o_tree_valid = tree_valid_q;
    assign o_tree       = tree_q;
    assign o_mode       = mode_q;

    // one frame in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        i_frame_valid |-> !busy);

endmodule

//--- src/ht_code_table.sv
/*
 * Code table builder
 * every leaf climbs toward the root one level per cycle,
 * collecting its branch bits into a right-aligned code
 */
`timescale 1ns/1ps

module ht_code_table import ht_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_tree_valid,
    input  huff_tree_t  i_tree,
    input  logic        i_mode,
    output logic        o_table_valid,
    output code_table_t o_table,
    output logic        o_mode
);

    huff_tree_t  tree_q;
    code_table_t table_q;
    node_idx_t   cur_q [NUM_SYM];
    logic        mode_q;
    logic        busy;
    logic [2:0]  step;
    logic        table_valid_q;
    logic        all_rooted;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            step          <= '0;
            table_valid_q <= 1'b0;
        end else begin
            table_valid_q <= 1'b0;
            if (i_tree_valid) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == 3'(MAX_CODE_LEN - 1)) begin   // deepest leaf done
                    busy          <= 1'b0;
                    table_valid_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_tree_valid) begin
            tree_q <= i_tree;
            mode_q <= i_mode;
            for (int s = 0; s < NUM_SYM; s++) begin
                cur_q[s]         <= node_idx_t'(s);
                table_q.entry[s] <= '0;
            end
        end else if (busy) begin
            for (int s = 0; s < NUM_SYM; s++) begin
                if (cur_q[s] != ROOT_NODE) begin
                    // earlier bits are nearer the leaf, so new bit goes above them
                    table_q.entry[s].bits[table_q.entry[s].len] <= tree_q.branch[cur_q[s]];
                    table_q.entry[s].len <= table_q.entry[s].len + 3'd1;
                    cur_q[s]             <= tree_q.parent[cur_q[s]];
                end
            end
        end
    end

    assign o_table_valid = table_valid_q;
    assign o_table       = table_q;
    assign o_mode        = mode_q;

    always_comb begin
        all_rooted = 1'b1;
        for (int s = 0; s < NUM_SYM; s++) begin
            if (cur_q[s] != ROOT_NODE) begin
                all_rooted = 1'b0;
            end
        end
    end

    // every leaf reached the root within the climb window
    a_len_range: assert property (@(posedge clk) disable iff (!rst_n)
        o_table_valid |-> all_rooted);

endmodule

//--- src/ht_code_serial.sv
/*
 * Code serializer
 * emits the codes of the five word letters one bit per cycle, MSB first
 */
`timescale 1ns/1ps

module ht_code_serial import ht_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_table_valid,
    input  code_table_t i_table,
    input  logic        i_mode,
    output logic        o_out_valid,
    output logic        o_out_code
);

    code_table_t               tab_q;
    logic                      mode_q;
    logic                      out_valid_q;
    logic [2:0]                let_q;     // letter in word
    logic [2:0]                bit_q;     // bit within current code
    logic [2:0]                let_nxt;
    sym_idx_t [WORD_LEN-1:0]   word;
    sym_idx_t [WORD_LEN-1:0]   in_word;
    code_entry_t               cur_entry;

    assign word      = mode_q ? WORD_ICLAB : WORD_ILOVE;
    assign in_word   = i_mode ? WORD_ICLAB : WORD_ILOVE;
    assign let_nxt   = let_q + 3'd1;
    assign cur_entry = tab_q.entry[word[let_q]];

    // ==================
    // letter / bit walk
    // ==================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            let_q       <= '0;
            bit_q       <= '0;
        end else begin
            if (i_table_valid) begin
                out_valid_q <= 1'b1;
                let_q       <= '0;
                bit_q       <= i_table.entry[in_word[0]].len - 3'd1;
            end else if (out_valid_q) begin
                if (bit_q != 3'd0) begin
                    bit_q <= bit_q - 3'd1;
                end else if (let_q == 3'(WORD_LEN - 1)) begin
                    out_valid_q <= 1'b0;   // last bit of last letter
                end else begin
                    let_q <= let_nxt;
                    bit_q <= tab_q.entry[word[let_nxt]].len - 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_table_valid) begin
            tab_q  <= i_table;
            mode_q <= i_mode;
        end
    end

    assign o_out_valid = out_valid_q;
    assign o_out_code  = out_valid_q & cur_entry.bits[bit_q];

    // upstream must wait for the word to finish
    a_no_table_busy: assert property (@(posedge clk) disable iff (!rst_n)
        i_table_valid |-> !out_valid_q);

endmodule

//--- src/ht_top.sv
/*
 * Huffman coder top
 * collect -> tree build -> code table -> serializer
 */
`timescale 1ns/1ps

module ht_top import ht_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    i_in_valid,
    input  weight_t i_weight,
    input  logic    i_out_mode,
    output logic    o_out_valid,
    output logic    o_out_code
);

    logic          frame_valid;
    weight_frame_t frame;
    logic          tree_valid;
    huff_tree_t    tree;
    logic          tree_mode;
    logic          table_valid;
    code_table_t   table_w;
    logic          table_mode;

    ht_weight_collect u_collect (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_in_valid    (i_in_valid),
        .i_weight      (i_weight),
        .i_out_mode    (i_out_mode),
        .o_frame_valid (frame_valid),
        .o_frame       (frame)
    );

    ht_tree_build u_tree (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_frame_valid (frame_valid),
        .i_frame       (frame),
        .o_tree_valid  (tree_valid),
        .o_tree        (tree),
        .o_mode        (tree_mode)
    );

    ht_code_table u_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_tree_valid  (tree_valid),
        .i_tree        (tree),
        .i_mode        (tree_mode),
        .o_table_valid (table_valid),
        .o_table       (table_w),
        .o_mode        (table_mode)
    );

    ht_code_serial u_serial (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_table_valid (table_valid),
        .i_table       (table_w),
        .i_mode        (table_mode),
        .o_out_valid   (o_out_valid),
        .o_out_code    (o_out_code)
    );

endmodule

//--- tb/tb_ht_top.sv
/*
 * Testbench for the Huffman coder top level
 * replays frames from the trace file, checks every serial code bit,
 * the length of each output burst and the idle outputs after reset
 */
`timescale 1ns/1ps

module tb_ht_top import ht_pkg::*; ();

    localparam int CLK_HALF      = 4;
    localparam int DRIVE_DLY     = 1;
    localparam int RESET_CYCLES  = 3;
    localparam int IDLE_CYCLES   = 5;
    localparam int TRACE_COLS    = 11;   // mode, 8 weights, count, bits
    localparam int MAX_FRAMES    = 64;
    localparam int FRAME_CYCLES  = 60;
    localparam int FIRST_OUT_MAX = 30;
    localparam int MAX_BITS      = 40;

    logic    clk;
    logic    rst_n;
    logic    i_in_valid;
    weight_t i_weight;
    logic    i_out_mode;
    logic    o_out_valid;
    logic    o_out_code;

    logic [31:0] trace_mem [MAX_FRAMES*TRACE_COLS];
    int          num_frames;
    logic        trace_ready;
    int          bit_errors;
    int          len_errors;
    int          other_errors;

    ht_top u_ht_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_in_valid  (i_in_valid),
        .i_weight    (i_weight),
        .i_out_mode  (i_out_mode),
        .o_out_valid (o_out_valid),
        .o_out_code  (o_out_code)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // ==================
    // compare tasks
    // ==================
    task automatic check_bit(input string name, input int idx, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errors++;
            $display("FAILED %s [%0d]: expected 0x%0h got 0x%0h", name, idx, exp, act);
        end
    endtask

    task automatic check_len(input int frame, input int exp, input int act);
        if (act != exp) begin
            len_errors++;
            $display("FAILED o_out_valid length, frame %0d: expected 0x%0h got 0x%0h",
                     frame, exp, act);
        end
    endtask

    function automatic logic [31:0] trace_field(input int frame, input int col);
        return trace_mem[frame*TRACE_COLS + col];
    endfunction

    task automatic load_trace();
        for (int a = 0; a < MAX_FRAMES*TRACE_COLS; a++) begin
            trace_mem[a] = 32'hf000_0000 | 32'(a);   // never a valid mode word
        end
        $readmemh("tb/ht_trace.txt", trace_mem);
        num_frames = 0;
        while (num_frames < MAX_FRAMES && trace_mem[num_frames*TRACE_COLS] <= 32'd1) begin
            num_frames++;
        end
    endtask

    // ==================
    // frame drive / output capture
    // ==================
    task automatic drive_frame(input int frame);
        logic [31:0] w;
        logic        mode;
        w    = trace_field(frame, 0);
        mode = w[0];
        for (int s = 0; s < NUM_SYM; s++) begin
            @(posedge clk);
            #DRIVE_DLY;
            w          = trace_field(frame, 1 + s);
            i_in_valid = 1'b1;
            i_weight   = w[2:0];
            i_out_mode = (s == 0) ? mode : ~mode;   // only slot 0 should stick
        end
        @(posedge clk);
        #DRIVE_DLY;
        i_in_valid = 1'b0;
        i_weight   = '0;
        i_out_mode = 1'b0;
    endtask

    task automatic collect_output(input int frame);
        logic [31:0] exp_bits;
        int          exp_len;
        int          got;
        int          wait_cyc;
        exp_len  = int'(trace_field(frame, 9));
        exp_bits = trace_field(frame, 10);
        wait_cyc = 0;
        @(negedge clk);
        while (!o_out_valid && wait_cyc < FIRST_OUT_MAX) begin
            check_bit("o_out_code idle", wait_cyc, 1'b0, o_out_code);
            wait_cyc++;
            @(negedge clk);
        end
        if (!o_out_valid) begin
            other_errors++;
            $display("frame %0d produced no output within %0d cycles of its last weight",
                     frame, FIRST_OUT_MAX);
            return;
        end
        got = 0;
        while (o_out_valid && got < MAX_BITS) begin
            if (got < exp_len) begin
                check_bit("o_out_code", got, exp_bits[31], o_out_code);
            end
            exp_bits = exp_bits << 1;
            got++;
            @(negedge clk);
        end
        if (o_out_valid) begin
            other_errors++;
            $display("frame %0d: output still running after %0d bits", frame, MAX_BITS);
        end
        check_len(frame, exp_len, got);
        check_bit("o_out_code after frame", got, 1'b0, o_out_code);
    endtask

    // ==================
    // main sequence
    // ==================
    initial begin
        rst_n        = 1'b0;
        i_in_valid   = 1'b0;
        i_weight     = '0;
        i_out_mode   = 1'b0;
        trace_ready  = 1'b0;
        bit_errors   = 0;
        len_errors   = 0;
        other_errors = 0;
        load_trace();
        trace_ready = 1'b1;
        if (num_frames == 0) begin
            other_errors++;
            $display("trace file holds no frames");
        end

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            check_bit("o_out_valid in reset", c, 1'b0, o_out_valid);
            check_bit("o_out_code in reset", c, 1'b0, o_out_code);
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        for (int c = 0; c < IDLE_CYCLES; c++) begin   // quiet until first frame
            @(negedge clk);
            check_bit("o_out_valid after reset", c, 1'b0, o_out_valid);
            check_bit("o_out_code after reset", c, 1'b0, o_out_code);
        end

        // next frame starts right after the previous burst ends
        for (int f = 0; f < num_frames; f++) begin
            drive_frame(f);
            collect_output(f);
        end

        $display("errors: bit=%0d length=%0d other=%0d frames=%0d",
                 bit_errors, len_errors, other_errors, num_frames);
        if (bit_errors + len_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (trace_ready);
        limit = num_frames * FRAME_CYCLES + RESET_CYCLES + IDLE_CYCLES + FRAME_CYCLES;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("errors: bit=%0d length=%0d other=%0d frames=%0d",
                 bit_errors, len_errors, other_errors + 1, num_frames);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- vlog.f
src/ht_pkg.sv
src/ht_weight_collect.sv
src/ht_tree_build.sv
src/ht_code_table.sv
src/ht_code_serial.sv
src/ht_top.sv
tb/tb_ht_top.sv

//--- run.sh
#!/bin/sh
# compile and run the Huffman coder testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_ht_top -o sim_ht &&
    ./obj_dir/sim_ht 2>&1 | tee /dev/stderr | grep -xF '** PASS **' > /dev/null ||
    { echo "simulation failed"; exit 1; }

echo "simulation passed"

//--- tb/ht_trace.txt
// mode  A B C E I L O V  bit_count  code_bits (left-aligned, first bit in bit 31)
// bit_count and code_bits are hex
0  1 2 3 4 5 6 7 0  0f  13f20000   // distinct weights, ILOVE
1  1 2 3 4 5 6 7 0  11  1af70000   // distinct weights, ICLAB
1  4 7 1 6 2 5 3 0  11  ef028000
0  4 7 1 6 2 5 3 0  11  e1bf0000
0  3 3 3 3 3 3 3 3  0f  de520000   // all equal, balanced tree
1  0 0 0 0 0 0 0 0  11  f6f90000   // all zero, chain tree
0  0 0 0 0 0 0 0 0  1d  f7dfbff0   // deepest codes, 29 bits
1  2 2 5 1 1 2 5 1  10  81ee0000   // mixed ties
0  2 2 5 1 1 2 5 1  13  87632000
1  7 7 7 7 7 7 7 7  0f  c3a60000   // largest sums
0  0 0 7 7 0 7 0 7  13  787d6000
1  0 0 7 7 0 7 0 7  13  7a19c000
